//--- design/bus_monitor.sv
`timescale 1ns/100ps
// One SCL/SDA pair and strobes lag the pins by 3 + FilterCycles clocks with FilterCycles of 1 or more
module bus_monitor #(
  parameter int unsigned FilterCycles = 2
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic start_o,
  output logic rstart_o,
  output logic stop_o,
  output logic bit_o,
  output logic bit_val_o,
  output logic scl_fall_o
);

  localparam int unsigned CntWidth = $clog2(FilterCycles + 1);

  // Index 0 is SCL and index 1 is SDA
  logic [1:0] pin_s1;
  logic [1:0] pin_s2;
  logic [1:0] pin_f;
  logic [1:0] pin_q;
  logic [CntWidth-1:0] cnt_q [2];
  logic busy_q;

  logic scl_hi;
  logic sda_fall;
  logic sda_rise;

  assign scl_hi   = pin_f[0] & pin_q[0];
  assign sda_fall = pin_q[1] & ~pin_f[1];
  assign sda_rise = ~pin_q[1] & pin_f[1];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pin_s1 <= '1;
      pin_s2 <= '1;
      pin_f  <= '1;
      pin_q  <= '1;
      for (int i = 0; i < 2; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      pin_s1 <= {sda_i, scl_i};
      pin_s2 <= pin_s1;
      pin_q  <= pin_f;
      // New level is taken once it has held for FilterCycles clocks
      for (int i = 0; i < 2; i++) begin
        if (pin_s2[i] == pin_f[i]) begin
          cnt_q[i] <= '0;
        end else if (cnt_q[i] == CntWidth'(FilterCycles - 1)) begin
          pin_f[i] <= pin_s2[i];
          cnt_q[i] <= '0;
        end else begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q     <= 1'b0;
      start_o    <= 1'b0;
      rstart_o   <= 1'b0;
      stop_o     <= 1'b0;
      bit_o      <= 1'b0;
      bit_val_o  <= 1'b1;
      scl_fall_o <= 1'b0;
    end else begin
      start_o    <= sda_fall & scl_hi & ~busy_q;
      rstart_o   <= sda_fall & scl_hi & busy_q;
      stop_o     <= sda_rise & scl_hi;
      bit_o      <= pin_f[0] & ~pin_q[0];
      bit_val_o  <= pin_f[1];
      scl_fall_o <= ~pin_f[0] & pin_q[0];
      if (sda_rise && scl_hi) begin
        busy_q <= 1'b0;
      end else if (sda_fall && scl_hi) begin
        busy_q <= 1'b1;
      end
    end
  end

endmodule

//--- design/controller_pkg.sv
// RX descriptor layout and status codes where overflow has priority over a parity error
package controller_pkg;

  localparam int unsigned RxDescWidth    = 32;
  localparam int unsigned DescCountLsb   = 0;
  localparam int unsigned DescCountWidth = 16;
  localparam int unsigned DescStatusLsb  = 16;
  localparam int unsigned DescModeBit    = 19;
  localparam int unsigned DescAddrLsb    = 20;

  typedef enum logic [2:0] {
    DESC_OK         = 3'd0,
    DESC_OVERFLOW   = 3'd1,
    DESC_PARITY_ERR = 3'd2
  } desc_status_e;

  // Bits 31:27 stay zero
  function automatic logic [RxDescWidth-1:0] pack_desc(
    input logic [DescCountWidth-1:0] count,
    input desc_status_e              status,
    input logic                      mode,
    input logic [6:0]                addr
  );
    logic [RxDescWidth-1:0] desc;
    desc = '0;
    desc[DescCountLsb +: DescCountWidth] = count;
    desc[DescStatusLsb +: 3] = status;
    desc[DescModeBit] = mode;
    desc[DescAddrLsb +: 7] = addr;
    return desc;
  endfunction

endpackage

//--- design/controller_standby.sv
`timescale 1ns/100ps
// Mode is sampled at START so i3c_en_i should only change while the bus is idle
module controller_standby (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   i3c_en_i,
  input  logic [6:0]                             sta_addr_i,
  input  logic [6:0]                             dyn_addr_i,
  input  logic                                   dyn_addr_valid_i,
  input  logic                                   start_i,
  input  logic                                   rstart_i,
  input  logic                                   stop_i,
  input  logic                                   bit_i,
  input  logic                                   bit_val_i,
  input  logic                                   scl_fall_i,
  input  logic                                   rx_queue_wready_i,
  input  logic                                   rx_desc_queue_wready_i,
  output logic                                   sda_o,
  output logic                                   rx_queue_wvalid_o,
  output logic [7:0]                             rx_queue_wdata_o,
  output logic                                   rx_desc_queue_wvalid_o,
  output logic [controller_pkg::RxDescWidth-1:0] rx_desc_queue_wdata_o,
  output logic [7:0]                             bus_addr_o,
  output logic                                   bus_addr_valid_o
);

  // 1 selects I3C
  logic mode_q;
  logic sel;
  logic [4:0] strb;
  logic [4:0] i2c_strb;
  logic [4:0] i3c_strb;

  logic                                   i2c_sda;
  logic                                   i3c_sda;
  logic                                   i2c_rx_wvalid;
  logic                                   i3c_rx_wvalid;
  logic [7:0]                             i2c_rx_wdata;
  logic [7:0]                             i3c_rx_wdata;
  logic                                   i2c_desc_wvalid;
  logic                                   i3c_desc_wvalid;
  logic [controller_pkg::RxDescWidth-1:0] i2c_desc_wdata;
  logic [controller_pkg::RxDescWidth-1:0] i3c_desc_wdata;
  logic [7:0]                             i2c_bus_addr;
  logic [7:0]                             i3c_bus_addr;
  logic                                   i2c_bus_addr_valid;
  logic                                   i3c_bus_addr_valid;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mode_q <= 1'b0;
    end else if (start_i) begin
      mode_q <= i3c_en_i;
    end
  end

  // START itself goes to the newly requested engine
  assign sel      = start_i ? i3c_en_i : mode_q;
  assign strb     = {start_i, rstart_i, stop_i, bit_i, scl_fall_i};
  assign i2c_strb = strb & {5{~sel}};
  assign i3c_strb = strb & {5{sel}};

  always_comb begin
    sda_o                  = mode_q ? i3c_sda : i2c_sda;
    rx_queue_wvalid_o      = mode_q ? i3c_rx_wvalid : i2c_rx_wvalid;
    rx_queue_wdata_o       = mode_q ? i3c_rx_wdata : i2c_rx_wdata;
    rx_desc_queue_wvalid_o = mode_q ? i3c_desc_wvalid : i2c_desc_wvalid;
    rx_desc_queue_wdata_o  = mode_q ? i3c_desc_wdata : i2c_desc_wdata;
    bus_addr_o             = mode_q ? i3c_bus_addr : i2c_bus_addr;
    bus_addr_valid_o       = mode_q ? i3c_bus_addr_valid : i2c_bus_addr_valid;
  end

  target_i2c_fsm xtarget_i2c_fsm (
    .clk_i                  (clk_i),
    .reset_i                (reset_i),
    .start_i                (i2c_strb[4]),
    .rstart_i               (i2c_strb[3]),
    .stop_i                 (i2c_strb[2]),
    .bit_i                  (i2c_strb[1]),
    .bit_val_i              (bit_val_i),
    .scl_fall_i             (i2c_strb[0]),
    .rx_queue_wready_i      (rx_queue_wready_i),
    .rx_desc_queue_wready_i (rx_desc_queue_wready_i),
    .sta_addr_i             (sta_addr_i),
    .sda_o                  (i2c_sda),
    .rx_queue_wvalid_o      (i2c_rx_wvalid),
    .rx_queue_wdata_o       (i2c_rx_wdata),
    .rx_desc_queue_wvalid_o (i2c_desc_wvalid),
    .rx_desc_queue_wdata_o  (i2c_desc_wdata),
    .bus_addr_o             (i2c_bus_addr),
    .bus_addr_valid_o       (i2c_bus_addr_valid)
  );

  target_i3c_fsm xtarget_i3c_fsm (
    .clk_i                  (clk_i),
    .reset_i                (reset_i),
    .start_i                (i3c_strb[4]),
    .rstart_i               (i3c_strb[3]),
    .stop_i                 (i3c_strb[2]),
    .bit_i                  (i3c_strb[1]),
    .bit_val_i              (bit_val_i),
    .scl_fall_i             (i3c_strb[0]),
    .rx_queue_wready_i      (rx_queue_wready_i),
    .rx_desc_queue_wready_i (rx_desc_queue_wready_i),
    .dyn_addr_i             (dyn_addr_i),
    .dyn_addr_valid_i       (dyn_addr_valid_i),
    .sda_o                  (i3c_sda),
    .rx_queue_wvalid_o      (i3c_rx_wvalid),
    .rx_queue_wdata_o       (i3c_rx_wdata),
    .rx_desc_queue_wvalid_o (i3c_desc_wvalid),
    .rx_desc_queue_wdata_o  (i3c_desc_wdata),
    .bus_addr_o             (i3c_bus_addr),
    .bus_addr_valid_o       (i3c_bus_addr_valid)
  );

endmodule

//--- design/i3c_pkg.sv
// Bus protocol types used by both target engines and no CCC codes since CCCs are not handled
package i3c_pkg;

  // Engine phase within one frame
  // DATA_ACK is used only by I2C and DATA_TBIT only by I3C
  typedef enum logic [2:0] {
    IDLE,
    ADDR,
    ADDR_ACK,
    DATA,
    DATA_ACK,
    DATA_TBIT,
    WAIT_STOP
  } bus_phase_e;

  // Level the target puts on SDA in an acknowledge slot
  typedef enum logic {
    ACK  = 1'b0,
    NACK = 1'b1
  } ack_e;

  // I3C broadcast header, always NACKed here
  localparam logic [6:0] BroadcastAddr = 7'h7E;

endpackage

//--- design/i3c_target_top.sv
`timescale 1ns/100ps
// Open-drain SDA where sda_o low pulls the line and the board resolves it with the controller driver
module i3c_target_top #(
  parameter int unsigned FilterCycles = 2
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   scl_i,
  input  logic                                   sda_i,
  output logic                                   sda_o,
  input  logic                                   i3c_en_i,
  input  logic [6:0]                             sta_addr_i,
  input  logic [6:0]                             dyn_addr_i,
  input  logic                                   dyn_addr_valid_i,
  output logic                                   rx_queue_wvalid_o,
  input  logic                                   rx_queue_wready_i,
  output logic [7:0]                             rx_queue_wdata_o,
  output logic                                   rx_desc_queue_wvalid_o,
  input  logic                                   rx_desc_queue_wready_i,
  output logic [controller_pkg::RxDescWidth-1:0] rx_desc_queue_wdata_o,
  output logic                                   bus_start_o,
  output logic                                   bus_rstart_o,
  output logic                                   bus_stop_o,
  output logic [7:0]                             bus_addr_o,
  output logic                                   bus_addr_valid_o
);

  logic bit_strb;
  logic bit_val;
  logic scl_fall;

  bus_monitor #(
    .FilterCycles (FilterCycles)
  ) xbus_monitor (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .scl_i      (scl_i),
    .sda_i      (sda_i),
    .start_o    (bus_start_o),
    .rstart_o   (bus_rstart_o),
    .stop_o     (bus_stop_o),
    .bit_o      (bit_strb),
    .bit_val_o  (bit_val),
    .scl_fall_o (scl_fall)
  );

  controller_standby xcontroller_standby (
    .clk_i                  (clk_i),
    .reset_i                (reset_i),
    .i3c_en_i               (i3c_en_i),
    .sta_addr_i             (sta_addr_i),
    .dyn_addr_i             (dyn_addr_i),
    .dyn_addr_valid_i       (dyn_addr_valid_i),
    .start_i                (bus_start_o),
    .rstart_i               (bus_rstart_o),
    .stop_i                 (bus_stop_o),
    .bit_i                  (bit_strb),
    .bit_val_i              (bit_val),
    .scl_fall_i             (scl_fall),
    .rx_queue_wready_i      (rx_queue_wready_i),
    .rx_desc_queue_wready_i (rx_desc_queue_wready_i),
    .sda_o                  (sda_o),
    .rx_queue_wvalid_o      (rx_queue_wvalid_o),
    .rx_queue_wdata_o       (rx_queue_wdata_o),
    .rx_desc_queue_wvalid_o (rx_desc_queue_wvalid_o),
    .rx_desc_queue_wdata_o  (rx_desc_queue_wdata_o),
    .bus_addr_o             (bus_addr_o),
    .bus_addr_valid_o       (bus_addr_valid_o)
  );

endmodule

//--- design/target_i2c_fsm.sv
`timescale 1ns/100ps
// Write-only I2C target where reads get a NACK and a descriptor arriving while one is pending is lost
module target_i2c_fsm (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   start_i,
  input  logic                                   rstart_i,
  input  logic                                   stop_i,
  input  logic                                   bit_i,
  input  logic                                   bit_val_i,
  input  logic                                   scl_fall_i,
  input  logic                                   rx_queue_wready_i,
  input  logic                                   rx_desc_queue_wready_i,
  input  logic [6:0]                             sta_addr_i,
  output logic                                   sda_o,
  output logic                                   rx_queue_wvalid_o,
  output logic [7:0]                             rx_queue_wdata_o,
  output logic                                   rx_desc_queue_wvalid_o,
  output logic [controller_pkg::RxDescWidth-1:0] rx_desc_queue_wdata_o,
  output logic [7:0]                             bus_addr_o,
  output logic                                   bus_addr_valid_o
);
  import i3c_pkg::*;
  import controller_pkg::*;

  bus_phase_e   state_q;
  ack_e         ack_q;
  desc_status_e status_q;
  logic [7:0]   shift_q;
  logic [2:0]   bit_cnt_q;
  logic [15:0]  byte_cnt_q;
  logic         accepted_q;

  logic [7:0] byte_w;
  logic       rx_busy;
  logic       addr_done;
  logic       byte_done;
  logic       desc_push;

  assign byte_w    = {shift_q[6:0], bit_val_i};
  assign rx_busy   = rx_queue_wvalid_o & ~rx_queue_wready_i;
  assign addr_done = bit_i && state_q == ADDR && bit_cnt_q == 3'd7;
  assign byte_done = bit_i && state_q == DATA && bit_cnt_q == 3'd7;
  assign desc_push = (rstart_i || stop_i) && accepted_q &&
                     !(rx_desc_queue_wvalid_o && !rx_desc_queue_wready_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q                <= IDLE;
      ack_q                  <= NACK;
      status_q               <= DESC_OK;
      bit_cnt_q              <= '0;
      byte_cnt_q             <= '0;
      accepted_q             <= 1'b0;
      sda_o                  <= 1'b1;
      rx_queue_wvalid_o      <= 1'b0;
      rx_desc_queue_wvalid_o <= 1'b0;
      bus_addr_valid_o       <= 1'b0;
    end else begin
      bus_addr_valid_o <= addr_done;
      if (rx_queue_wready_i) begin
        rx_queue_wvalid_o <= 1'b0;
      end
      if (rx_desc_queue_wready_i) begin
        rx_desc_queue_wvalid_o <= 1'b0;
      end
      // Drive the ACK slot on its falling edge and release on the next one
      if (scl_fall_i) begin
        sda_o <= (state_q == ADDR_ACK || state_q == DATA_ACK) ? ack_q : 1'b1;
      end

      if (start_i || rstart_i || stop_i) begin
        if (desc_push) begin
          rx_desc_queue_wvalid_o <= 1'b1;
        end
        accepted_q <= 1'b0;
        sda_o      <= 1'b1;
        bit_cnt_q  <= '0;
        byte_cnt_q <= '0;
        status_q   <= DESC_OK;
        state_q    <= stop_i ? IDLE : ADDR;
      end else if (bit_i) begin
        unique case (state_q)
          ADDR: begin
            bit_cnt_q <= bit_cnt_q + 3'd1;
            if (addr_done) begin
              // Write to the static address only
              if (shift_q[6:0] == sta_addr_i && !bit_val_i) begin
                ack_q      <= ACK;
                accepted_q <= 1'b1;
              end else begin
                ack_q <= NACK;
              end
              state_q <= ADDR_ACK;
            end
          end
          ADDR_ACK: state_q <= accepted_q ? DATA : WAIT_STOP;
          DATA: begin
            bit_cnt_q <= bit_cnt_q + 3'd1;
            if (byte_done) begin
              byte_cnt_q <= byte_cnt_q + 16'd1;
              if (rx_busy) begin
                status_q <= DESC_OVERFLOW;
              end else begin
                rx_queue_wvalid_o <= 1'b1;
              end
              ack_q   <= ACK;
              state_q <= DATA_ACK;
            end
          end
          DATA_ACK: state_q <= DATA;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bit_i) begin
      shift_q <= byte_w;
    end
    if (addr_done) begin
      bus_addr_o <= byte_w;
    end
    if (byte_done && !rx_busy) begin
      rx_queue_wdata_o <= byte_w;
    end
    if (desc_push) begin
      rx_desc_queue_wdata_o <= pack_desc(byte_cnt_q, status_q, 1'b0, bus_addr_o[7:1]);
    end
  end

endmodule

//--- design/target_i3c_fsm.sv
`timescale 1ns/100ps
// I3C SDR private writes only and the header is NACKed unless the dynamic address is valid
module target_i3c_fsm (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   start_i,
  input  logic                                   rstart_i,
  input  logic                                   stop_i,
  input  logic                                   bit_i,
  input  logic                                   bit_val_i,
  input  logic                                   scl_fall_i,
  input  logic                                   rx_queue_wready_i,
  input  logic                                   rx_desc_queue_wready_i,
  input  logic [6:0]                             dyn_addr_i,
  input  logic                                   dyn_addr_valid_i,
  output logic                                   sda_o,
  output logic                                   rx_queue_wvalid_o,
  output logic [7:0]                             rx_queue_wdata_o,
  output logic                                   rx_desc_queue_wvalid_o,
  output logic [controller_pkg::RxDescWidth-1:0] rx_desc_queue_wdata_o,
  output logic [7:0]                             bus_addr_o,
  output logic                                   bus_addr_valid_o
);
  import i3c_pkg::*;
  import controller_pkg::*;

  bus_phase_e   state_q;
  ack_e         ack_q;
  desc_status_e status_q;
  logic [7:0]   shift_q;
  logic [2:0]   bit_cnt_q;
  logic [15:0]  byte_cnt_q;
  logic         accepted_q;

  logic [7:0] byte_w;
  logic       rx_busy;
  logic       addr_done;
  logic       tbit_done;
  logic       parity_ok;
  logic       desc_push;
  logic       hdr_match;

  assign byte_w    = {shift_q[6:0], bit_val_i};
  assign rx_busy   = rx_queue_wvalid_o & ~rx_queue_wready_i;
  assign addr_done = bit_i && state_q == ADDR && bit_cnt_q == 3'd7;
  assign tbit_done = bit_i && state_q == DATA_TBIT;
  // Odd parity over data byte and T-bit
  assign parity_ok = ^{shift_q, bit_val_i};
  assign hdr_match = dyn_addr_valid_i && shift_q[6:0] == dyn_addr_i &&
                     shift_q[6:0] != BroadcastAddr && !bit_val_i;
  assign desc_push = (rstart_i || stop_i) && accepted_q &&
                     !(rx_desc_queue_wvalid_o && !rx_desc_queue_wready_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q                <= IDLE;
      ack_q                  <= NACK;
      status_q               <= DESC_OK;
      bit_cnt_q              <= '0;
      byte_cnt_q             <= '0;
      accepted_q             <= 1'b0;
      sda_o                  <= 1'b1;
      rx_queue_wvalid_o      <= 1'b0;
      rx_desc_queue_wvalid_o <= 1'b0;
      bus_addr_valid_o       <= 1'b0;
    end else begin
      bus_addr_valid_o <= addr_done;
      if (rx_queue_wready_i) begin
        rx_queue_wvalid_o <= 1'b0;
      end
      if (rx_desc_queue_wready_i) begin
        rx_desc_queue_wvalid_o <= 1'b0;
      end
      // T-bit belongs to the controller so SDA is only driven in the header ACK
      if (scl_fall_i) begin
        sda_o <= (state_q == ADDR_ACK) ? ack_q : 1'b1;
      end

      if (start_i || rstart_i || stop_i) begin
        if (desc_push) begin
          rx_desc_queue_wvalid_o <= 1'b1;
        end
        accepted_q <= 1'b0;
        sda_o      <= 1'b1;
        bit_cnt_q  <= '0;
        byte_cnt_q <= '0;
        status_q   <= DESC_OK;
        state_q    <= stop_i ? IDLE : ADDR;
      end else if (bit_i) begin
        unique case (state_q)
          ADDR: begin
            bit_cnt_q <= bit_cnt_q + 3'd1;
            if (addr_done) begin
              ack_q      <= hdr_match ? ACK : NACK;
              accepted_q <= hdr_match;
              state_q    <= ADDR_ACK;
            end
          end
          ADDR_ACK: state_q <= accepted_q ? DATA : WAIT_STOP;
          DATA: begin
            bit_cnt_q <= bit_cnt_q + 3'd1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= DATA_TBIT;
            end
          end
          DATA_TBIT: begin
            if (!parity_ok) begin
              if (status_q != DESC_OVERFLOW) begin
                status_q <= DESC_PARITY_ERR;
              end
            end else begin
              byte_cnt_q <= byte_cnt_q + 16'd1;
              if (rx_busy) begin
                status_q <= DESC_OVERFLOW;
              end else begin
                rx_queue_wvalid_o <= 1'b1;
              end
            end
            state_q <= DATA;
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bit_i) begin
      shift_q <= byte_w;
    end
    if (addr_done) begin
      bus_addr_o <= byte_w;
    end
    // Shift register still holds the byte while the T-bit is sampled
    if (tbit_done && parity_ok && !rx_busy) begin
      rx_queue_wdata_o <= shift_q;
    end
    if (desc_push) begin
      rx_desc_queue_wdata_o <= pack_desc(byte_cnt_q, status_q, 1'b1, bus_addr_o[7:1]);
    end
  end

endmodule

//--- i3c_standby.f
+incdir+testbench
design/i3c_pkg.sv
design/controller_pkg.sv
design/bus_monitor.sv
design/target_i2c_fsm.sv
design/target_i3c_fsm.sv
design/controller_standby.sv
design/i3c_target_top.sv
testbench/tb_i3c_target.sv

//--- testbench/tb_bus_driver.svh
// Included inside the testbench module, tasks must be called 2 ns after a rising clock edge
`ifndef TB_BUS_DRIVER_SVH
`define TB_BUS_DRIVER_SVH

  // Advance n clocks and land just after the edge
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      data_lfsr = lfsr_next(data_lfsr);
      val = {val[6:0], data_lfsr[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      report_failure($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  // SDA falls while SCL is high
  task automatic send_start();
    step(8);
    sda_drv = 1'b0;
    step(16);
    scl_drv = 1'b0;
  endtask

  task automatic send_rstart();
    step(8);
    sda_drv = 1'b1;
    step(8);
    scl_drv = 1'b1;
    step(8);
    sda_drv = 1'b0;
    step(8);
    scl_drv = 1'b0;
  endtask

  // Leaves the bus idle with both lines high
  task automatic send_stop();
    step(8);
    sda_drv = 1'b0;
    step(8);
    scl_drv = 1'b1;
    step(8);
    sda_drv = 1'b1;
    step(16);
  endtask

  // Eight bits MSB first plus a ninth bit, returns the line level in the ninth slot
  task automatic send_byte(input logic [7:0] b, input logic ninth, output logic seen);
    logic [8:0] bits;
    bits = {b, ninth};
    seen = 1'b1;
    for (int i = 8; i >= 0; i--) begin
      step(8);
      sda_drv = bits[i];
      step(8);
      scl_drv = 1'b1;
      step(16);
      seen = sda_line;
      scl_drv = 1'b0;
    end
  endtask

`endif

//--- testbench/tb_i3c_target.sv
`timescale 1ns/100ps
// Runs with FilterCycles 2 and random queue ready and assumes each queued word drains between bytes
module tb_i3c_target;
  import i3c_pkg::*;
  import controller_pkg::*;

  localparam logic [6:0] StaAddr = 7'h2A;
  localparam logic [6:0] DynAddr = 7'h35;
  localparam int NumFrames = 11;
  // Header plus eight data bytes of nine bits, plus start, stop and idle gaps
  localparam int MaxFrameBits = 9 * 9 + 6;
  localparam int TimeoutClks = 2 * NumFrames * MaxFrameBits * 32;

  logic        clk;
  logic        reset;
  logic        scl_drv;
  logic        sda_drv;
  logic        sda_line;
  logic        sda_out;
  logic        i3c_en;
  logic [6:0]  sta_addr;
  logic [6:0]  dyn_addr;
  logic        dyn_addr_valid;
  logic        rx_wvalid;
  logic        rx_wready;
  logic [7:0]  rx_wdata;
  logic        desc_wvalid;
  logic        desc_wready;
  logic [31:0] desc_wdata;
  logic        bus_start;
  logic        bus_rstart;
  logic        bus_stop;
  logic [7:0]  bus_addr;
  logic        bus_addr_valid;

  logic [15:0] data_lfsr;
  logic [15:0] rdy_lfsr;
  logic        hold_rx;
  string       test_name;
  logic [7:0]  exp_data [$];
  logic [7:0]  act_data [$];
  logic [31:0] exp_desc [$];
  logic [31:0] act_desc [$];
  // Start, rstart, stop, address pulses
  int          pulse_cnt [4];
  int          pulse_base [4];

  // Open-drain line
  assign sda_line = sda_drv & sda_out;

  `include "tb_bus_driver.svh"

  i3c_target_top #(
    .FilterCycles (2)
  ) dut_i (
    .clk_i                  (clk),
    .reset_i                (reset),
    .scl_i                  (scl_drv),
    .sda_i                  (sda_line),
    .sda_o                  (sda_out),
    .i3c_en_i               (i3c_en),
    .sta_addr_i             (sta_addr),
    .dyn_addr_i             (dyn_addr),
    .dyn_addr_valid_i       (dyn_addr_valid),
    .rx_queue_wvalid_o      (rx_wvalid),
    .rx_queue_wready_i      (rx_wready),
    .rx_queue_wdata_o       (rx_wdata),
    .rx_desc_queue_wvalid_o (desc_wvalid),
    .rx_desc_queue_wready_i (desc_wready),
    .rx_desc_queue_wdata_o  (desc_wdata),
    .bus_start_o            (bus_start),
    .bus_rstart_o           (bus_rstart),
    .bus_stop_o             (bus_stop),
    .bus_addr_o             (bus_addr),
    .bus_addr_valid_o       (bus_addr_valid)
  );

  always #10 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  function automatic logic ref_accept(input logic mode, input logic [6:0] addr, input logic rnw);
    if (rnw) return 1'b0;
    if (mode) return dyn_addr_valid && addr == dyn_addr && addr != BroadcastAddr;
    return addr == sta_addr;
  endfunction

  // Expected descriptor and the mask of bytes that reach the data queue
  function automatic logic [31:0] ref_frame(input logic mode, input logic [6:0] addr,
                                            input int nbytes, input logic [7:0] bad_mask,
                                            input logic stall, output logic [7:0] keep);
    logic [15:0]  count;
    desc_status_e status;
    logic         pending;
    logic [31:0]  desc;
    count = '0;
    status = DESC_OK;
    pending = 1'b0;
    keep = '0;
    for (int i = 0; i < nbytes; i++) begin
      if (mode && bad_mask[i]) begin
        if (status != DESC_OVERFLOW) status = DESC_PARITY_ERR;
      end else begin
        count = count + 16'd1;
        if (pending) begin
          status = DESC_OVERFLOW;
        end else begin
          keep[i] = 1'b1;
          pending = stall;
        end
      end
    end
    desc = '0;
    desc[15:0] = count;
    desc[18:16] = status;
    desc[19] = mode;
    desc[26:20] = addr;
    return desc;
  endfunction

  task automatic run_frame(input string name, input logic [6:0] addr, input logic rnw,
                           input int nbytes, input logic [7:0] bad_mask);
    logic [7:0]  data [8];
    logic [7:0]  keep;
    logic [31:0] desc;
    logic        acc;
    logic        exp_ack;
    logic        seen;
    test_name = name;
    for (int i = 0; i < nbytes; i++) begin
      take_bits(8, data[i]);
    end
    acc = ref_accept(i3c_en, addr, rnw);
    exp_ack = ~acc;
    desc = ref_frame(i3c_en, addr, nbytes, bad_mask, hold_rx, keep);
    if (acc) begin
      for (int i = 0; i < nbytes; i++) begin
        if (keep[i]) exp_data.push_back(data[i]);
      end
      exp_desc.push_back(desc);
    end
    send_byte({addr, rnw}, 1'b1, seen);
    check_value({name, " header ack"}, exp_ack, seen);
    check_value({name, " bus addr"}, {24'd0, addr, rnw}, bus_addr);
    for (int i = 0; i < nbytes; i++) begin
      if (i3c_en) begin
        // T-bit gives odd parity unless this byte is marked bad
        send_byte(data[i], ~^data[i] ^ bad_mask[i], seen);
      end else begin
        send_byte(data[i], 1'b1, seen);
        check_value({name, " data ack"}, exp_ack, seen);
      end
    end
  endtask

  task automatic end_test(input string name, input int s, input int r, input int p, input int a);
    while (exp_data.size() != 0 || exp_desc.size() != 0) begin
      step(1);
    end
    check_value({name, " start pulses"}, s, pulse_cnt[0] - pulse_base[0]);
    check_value({name, " rstart pulses"}, r, pulse_cnt[1] - pulse_base[1]);
    check_value({name, " stop pulses"}, p, pulse_cnt[2] - pulse_base[2]);
    check_value({name, " addr pulses"}, a, pulse_cnt[3] - pulse_base[3]);
    for (int i = 0; i < 4; i++) begin
      pulse_base[i] = pulse_cnt[i];
    end
    step(32);
  endtask

  // Random ready for both queues with data ready forced low by hold_rx
  always @(posedge clk) begin
    #2;
    rdy_lfsr = lfsr_next(rdy_lfsr);
    desc_wready = rdy_lfsr[0];
    rdy_lfsr = lfsr_next(rdy_lfsr);
    rx_wready = rdy_lfsr[0] & ~hold_rx;
  end

  always @(posedge clk) begin
    if (!reset) begin
      if (rx_wvalid && rx_wready) act_data.push_back(rx_wdata);
      if (desc_wvalid && desc_wready) act_desc.push_back(desc_wdata);
      pulse_cnt[0] += bus_start;
      pulse_cnt[1] += bus_rstart;
      pulse_cnt[2] += bus_stop;
      pulse_cnt[3] += bus_addr_valid;
    end
  end

  always @(negedge clk) begin : compare_queues
    logic [7:0]  byte_act;
    logic [31:0] desc_act;
    if (act_data.size() != 0) begin
      byte_act = act_data.pop_front();
      if (exp_data.size() == 0) begin
        report_failure($sformatf("Unexpected data byte %h in test %s", byte_act, test_name));
      end else begin
        check_value({test_name, " data"}, exp_data.pop_front(), byte_act);
      end
    end
    if (act_desc.size() != 0) begin
      desc_act = act_desc.pop_front();
      if (exp_desc.size() == 0) begin
        report_failure($sformatf("Unexpected descriptor %h in test %s", desc_act, test_name));
      end else begin
        check_value({test_name, " descriptor"}, exp_desc.pop_front(), desc_act);
      end
    end
  end

  initial begin
    repeat (TimeoutClks) @(posedge clk);
    report_failure("Timeout: the tests did not finish within the allowed time");
  end

  initial begin : main_sequence
    logic [7:0] len;
    clk = 1'b0;
    reset = 1'b1;
    scl_drv = 1'b1;
    sda_drv = 1'b1;
    i3c_en = 1'b0;
    sta_addr = StaAddr;
    dyn_addr = DynAddr;
    dyn_addr_valid = 1'b1;
    rx_wready = 1'b0;
    desc_wready = 1'b0;
    hold_rx = 1'b0;
    data_lfsr = 16'd3053;
    rdy_lfsr = 16'd3053;
    test_name = "reset";
    for (int i = 0; i < 4; i++) begin
      pulse_cnt[i] = 0;
      pulse_base[i] = 0;
    end
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    check_value("reset outputs", 3'b001, {rx_wvalid, desc_wvalid, sda_out});
    step(16);

    repeat (2) begin
      take_bits(3, len);
      send_start();
      run_frame("i2c_write", StaAddr, 1'b0, len + 1, 8'h00);
      send_stop();
      end_test("i2c_write", 1, 0, 1, 1);
    end
    send_start();
    run_frame("i2c_wrong_addr", StaAddr ^ 7'h01, 1'b0, 1, 8'h00);
    send_stop();
    end_test("i2c_wrong_addr", 1, 0, 1, 1);
    send_start();
    run_frame("i2c_read", StaAddr, 1'b1, 0, 8'h00);
    send_stop();
    end_test("i2c_read", 1, 0, 1, 1);

    i3c_en = 1'b1;
    take_bits(3, len);
    send_start();
    run_frame("i3c_write", DynAddr, 1'b0, len + 1, 8'h00);
    send_stop();
    end_test("i3c_write", 1, 0, 1, 1);
    // Broadcast address doubles as the dynamic address here
    dyn_addr = BroadcastAddr;
    send_start();
    run_frame("i3c_broadcast", BroadcastAddr, 1'b0, 0, 8'h00);
    send_stop();
    end_test("i3c_broadcast", 1, 0, 1, 1);
    dyn_addr = DynAddr;
    dyn_addr_valid = 1'b0;
    send_start();
    run_frame("i3c_no_dyn_addr", DynAddr, 1'b0, 1, 8'h00);
    send_stop();
    end_test("i3c_no_dyn_addr", 1, 0, 1, 1);
    dyn_addr_valid = 1'b1;
    // Third byte carries a wrong T-bit
    send_start();
    run_frame("i3c_parity", DynAddr, 1'b0, 4, 8'b0000_0100);
    send_stop();
    end_test("i3c_parity", 1, 0, 1, 1);

    i3c_en = 1'b0;
    hold_rx = 1'b1;
    send_start();
    run_frame("i2c_overflow", StaAddr, 1'b0, 3, 8'h00);
    send_stop();
    hold_rx = 1'b0;
    end_test("i2c_overflow", 1, 0, 1, 1);

    send_start();
    run_frame("rstart_first", StaAddr, 1'b0, 2, 8'h00);
    send_rstart();
    run_frame("rstart_second", StaAddr, 1'b0, 3, 8'h00);
    send_stop();
    end_test("rstart", 1, 1, 1, 2);

    if (exp_data.size() == 0 && exp_desc.size() == 0 && act_data.size() == 0 &&
        act_desc.size() == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      report_failure("Queue outputs were still outstanding at the end of the run");
    end
  end

endmodule
